//--- ray_gen_top.f
ray_pkg.sv
pixel_counter.sv
frame_sequencer.sv
ray_generator.sv
vec3_normalizer.sv
ray_gen_top.sv
tb_ray_gen_top.sv

//--- tb_ray_gen_top.sv
`timescale 1ns/1ps

module tb_ray_gen_top
  import ray_pkg::*;
();

  localparam int  NUM_FRAMES        = 4;
  localparam int  RESET_CYCLES      = 8;
  localparam int  FRAME_PIXELS      = DISPLAY_WIDTH * DISPLAY_HEIGHT;
  // pixel (0,0) one cycle after start and six pipeline stages on top
  localparam int  FIRST_RAY_DELAY   = 7;
  localparam int  STRAY_SCAN_CYCLE  = 100;
  localparam int  IDLE_CHECK_CYCLES = 6;
  localparam int  IDLE_GAP          = 4;
  localparam int  TIMEOUT_CYCLES    = NUM_FRAMES * (FRAME_PIXELS + 40) + RESET_CYCLES;
  // 2^-8 per component
  localparam int  TOL_LSB           = 256;
  localparam real TOL_REAL          = 1.0 / 256.0;
  localparam real FP_SCALE          = 65536.0;

  // one frame of stimulus as a camera plus three probe pixels
  typedef struct packed {
    vec3    cam;
    pixel_t corner;
    pixel_t center;
    pixel_t rand_pix;
  } stim_entry_t;

  logic clk_in;
  logic rst_n;
  logic start;
  vec3  cam_forward;
  logic ray_valid;
  ray_t ray;
  logic frame_done;
  logic busy;

  stim_entry_t stim_tab [NUM_FRAMES];
  int          mismatch_count;
  int          protocol_count;
  int          cycle_count;

  ray_gen_top uut (
    .clk_in      (clk_in),
    .rst_n       (rst_n),
    .start       (start),
    .cam_forward (cam_forward),
    .ray_valid   (ray_valid),
    .ray         (ray),
    .frame_done  (frame_done),
    .busy        (busy)
  );

  always #4 clk_in = ~clk_in;

  // watchdog on total run length
  always @(posedge clk_in) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  // round to nearest lsb
  function automatic fp to_fp(real r);
    real scaled;
    scaled = r * FP_SCALE;
    if (scaled >= 0.0) return fp'($rtoi(scaled + 0.5));
    return fp'($rtoi(scaled - 0.5));
  endfunction

  function automatic real to_real(fp a);
    return $itor(a) / FP_SCALE;
  endfunction

  function automatic vec3 vec_from_reals(real x, real y, real z);
    vec3 v;
    v.x = to_fp(x);
    v.y = to_fp(y);
    v.z = to_fp(z);
    return v;
  endfunction

  // raster position of the n-th ray with the column running fastest
  function automatic pixel_t pixel_at(int idx);
    pixel_t p;
    p.hcount = H_BITS'(idx % DISPLAY_WIDTH);
    p.vcount = V_BITS'(idx / DISPLAY_WIDTH);
    return p;
  endfunction

  // real-valued reference for one pixel
  function automatic vec3 model_dir(vec3 cam, pixel_t p);
    real fx;
    real fy;
    real fz;
    real sx;
    real sy;
    real dx;
    real dy;
    real dz;
    real len;
    vec3 d;
    fx = to_real(cam.x);
    fy = to_real(cam.y);
    fz = to_real(cam.z);
    sx = (2.0 * $itor(p.hcount) - $itor(DISPLAY_WIDTH)) / $itor(DISPLAY_HEIGHT);
    sy = (2.0 * $itor(p.vcount) - $itor(DISPLAY_HEIGHT)) / $itor(DISPLAY_HEIGHT);
    // right = (fz, 0, -fx) and up = f x right = (-fx*fy, fx^2 + fz^2, -fy*fz)
    dx = fz * sx - fx * fy * sy + fx;
    dy = (fx * fx + fz * fz) * sy + fy;
    dz = -fx * sx - fy * fz * sy + fz;
    len = $sqrt(dx * dx + dy * dy + dz * dz);
    d.x = to_fp(dx / len);
    // screen down is positive y
    d.y = to_fp(-dy / len);
    d.z = to_fp(dz / len);
    return d;
  endfunction

  task automatic check_pixel(string name, pixel_t got, pixel_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      mismatch_count++;
    end
  endtask

  task automatic check_vec3(string name, vec3 got, vec3 exp);
    longint dx;
    longint dy;
    longint dz;
    dx = longint'(got.x) - longint'(exp.x);
    dy = longint'(got.y) - longint'(exp.y);
    dz = longint'(got.z) - longint'(exp.z);
    if (dx < 0) dx = -dx;
    if (dy < 0) dy = -dy;
    if (dz < 0) dz = -dz;
    if ($isunknown(got) || dx > TOL_LSB || dy > TOL_LSB || dz > TOL_LSB) begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      mismatch_count++;
    end
  endtask

  task automatic check_unit(string name, vec3 got);
    real gx;
    real gy;
    real gz;
    real len;
    gx = to_real(got.x);
    gy = to_real(got.y);
    gz = to_real(got.z);
    len = $sqrt(gx * gx + gy * gy + gz * gz);
    if ($isunknown(got) || len - 1.0 > TOL_REAL || 1.0 - len > TOL_REAL) begin
      $display("MISMATCH %s length: got %h expected %h", name, to_fp(len), FP_ONE);
      mismatch_count++;
    end
  endtask

  task automatic build_table();
    stim_tab[0].cam = vec_from_reals(0.0, 0.0, 1.0);
    stim_tab[1].cam = vec_from_reals(0.6, 0.0, 0.8);
    stim_tab[2].cam = vec_from_reals(0.48, 0.6, 0.64);
    stim_tab[3].cam = vec_from_reals(-0.36, -0.48, 0.8);
    for (int i = 0; i < NUM_FRAMES; i++) begin
      // alternate top left and bottom right corners
      stim_tab[i].corner          = (i % 2 == 0) ? pixel_at(0) : pixel_at(FRAME_PIXELS - 1);
      stim_tab[i].center.hcount   = H_BITS'(DISPLAY_WIDTH / 2);
      stim_tab[i].center.vcount   = V_BITS'(DISPLAY_HEIGHT / 2);
      stim_tab[i].rand_pix.hcount = H_BITS'($urandom % DISPLAY_WIDTH);
      stim_tab[i].rand_pix.vcount = V_BITS'($urandom % DISPLAY_HEIGHT);
    end
  endtask

  task automatic run_frame(int idx);
    stim_entry_t e;
    int          since_start;
    int          ray_count;
    int          done_count;
    logic        prev_valid;
    pixel_t      exp_pix;
    e = stim_tab[idx];
    // loop begins in the cycle after the start cycle
    since_start = 1;
    ray_count = 0;
    done_count = 0;
    prev_valid = 1'b0;
    @(negedge clk_in);
    start = 1'b1;
    cam_forward = e.cam;
    @(negedge clk_in);
    start = 1'b0;
    // camera that must never be latched
    cam_forward = vec_from_reals(1.0, 0.0, 0.0);
    while (done_count == 0) begin
      if (!frame_done && busy !== 1'b1) begin
        $display("busy low at cycle %0d of frame %0d", since_start, idx);
        protocol_count++;
      end
      if (ray_valid) begin
        if (ray_count == 0 && since_start != FIRST_RAY_DELAY) begin
          $display("First ray of frame %0d came %0d cycles after start, expected %0d",
                   idx, since_start, FIRST_RAY_DELAY);
          protocol_count++;
        end
        if (ray_count > 0 && !prev_valid) begin
          $display("Gap in the ray stream of frame %0d before ray %0d", idx, ray_count);
          protocol_count++;
        end
        if (ray_count >= FRAME_PIXELS) begin
          $display("Frame %0d produced more than %0d rays", idx, FRAME_PIXELS);
          protocol_count++;
        end else begin
          exp_pix = pixel_at(ray_count);
          check_pixel("ray.pix", ray.pix, exp_pix);
          if (exp_pix == e.corner || exp_pix == e.center || exp_pix == e.rand_pix) begin
            check_vec3($sformatf("ray.dir (%0d,%0d)", exp_pix.hcount, exp_pix.vcount),
                       ray.dir, model_dir(e.cam, exp_pix));
            check_unit("ray.dir", ray.dir);
          end
        end
        ray_count++;
      end
      if (frame_done) begin
        done_count++;
        if (ray_valid || !prev_valid || ray_count != FRAME_PIXELS) begin
          $display("frame_done of frame %0d did not follow the last ray by one cycle", idx);
          protocol_count++;
        end
        if (busy !== 1'b0) begin
          $display("busy still high when frame_done pulsed in frame %0d", idx);
          protocol_count++;
        end
      end
      // stray starts once mid scan and once while the pipeline drains
      start = 1'b0;
      if (since_start == STRAY_SCAN_CYCLE) start = 1'b1;
      if (ray_valid && ray.pix == pixel_at(FRAME_PIXELS - 3)) start = 1'b1;
      prev_valid = ray_valid;
      @(negedge clk_in);
      since_start++;
    end
    start = 1'b0;
    if (ray_count != FRAME_PIXELS) begin
      $display("Frame %0d produced %0d rays instead of %0d", idx, ray_count, FRAME_PIXELS);
      protocol_count++;
    end
    // a taken stray start would show up here
    repeat (IDLE_GAP) begin
      if (ray_valid !== 1'b0 || frame_done !== 1'b0 || busy !== 1'b0) begin
        $display("Activity after frame_done of frame %0d, a stray start was taken", idx);
        protocol_count++;
      end
      @(negedge clk_in);
    end
  endtask

  initial begin
    clk_in = 1'b0;
    rst_n = 1'b0;
    start = 1'b0;
    cam_forward = '0;
    mismatch_count = 0;
    protocol_count = 0;
    cycle_count = 0;
    void'($urandom(77));
    build_table();
    repeat (RESET_CYCLES) @(posedge clk_in);
    @(negedge clk_in);
    rst_n = 1'b1;
    // quiet outputs before the first start
    repeat (IDLE_CHECK_CYCLES) begin
      @(negedge clk_in);
      if (ray_valid !== 1'b0 || frame_done !== 1'b0 || busy !== 1'b0) begin
        $display("Outputs not idle after reset before any start");
        protocol_count++;
      end
    end
    for (int i = 0; i < NUM_FRAMES; i++) begin
      run_frame(i);
    end
    $display("Errors: %0d mismatches, %0d protocol errors", mismatch_count, protocol_count);
    if (mismatch_count + protocol_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- ray_gen_top.sv
`timescale 1ns/1ps

module ray_gen_top
  import ray_pkg::*;
(
  input  logic clk_in,
  input  logic rst_n,
  input  logic start,
  input  vec3  cam_forward,
  output logic ray_valid,
  output ray_t ray,
  output logic frame_done,
  output logic busy
);

  // sequencer to counter
  logic step;
  logic clear;
  // counter back to sequencer and generator
  pixel_t pix;
  logic   last;
  // sequencer to generator
  logic pix_valid;
  vec3  cam;
  // generator to normalizer
  logic   gen_valid;
  pixel_t gen_pix;
  vec3    gen_dir;

  frame_sequencer u_frame_sequencer (
    .clk_in      (clk_in),
    .rst_n       (rst_n),
    .start       (start),
    .cam_forward (cam_forward),
    .last        (last),
    .step        (step),
    .clear       (clear),
    .pix_valid   (pix_valid),
    .cam         (cam),
    .busy        (busy),
    .frame_done  (frame_done)
  );

  pixel_counter u_pixel_counter (
    .clk_in (clk_in),
    .rst_n  (rst_n),
    .clear  (clear),
    .step   (step),
    .pix    (pix),
    .last   (last)
  );

  ray_generator u_ray_generator (
    .clk_in      (clk_in),
    .rst_n       (rst_n),
    .valid_in    (pix_valid),
    .pix         (pix),
    .cam_forward (cam),
    .valid_out   (gen_valid),
    .pix_out     (gen_pix),
    .dir_raw     (gen_dir)
  );

  vec3_normalizer u_vec3_normalizer (
    .clk_in    (clk_in),
    .rst_n     (rst_n),
    .valid_in  (gen_valid),
    .pix       (gen_pix),
    .dir_raw   (gen_dir),
    .ray_valid (ray_valid),
    .ray       (ray)
  );

endmodule

//--- vec3_normalizer.sv
`timescale 1ns/1ps

module vec3_normalizer
  import ray_pkg::*;
(
  input  logic   clk_in,
  input  logic   rst_n,
  input  logic   valid_in,
  input  pixel_t pix,
  input  vec3    dir_raw,
  output logic   ray_valid,
  output ray_t   ray
);

  // one newton iteration, y * (3/2 - len2 * y^2 / 2)
  function automatic fp newton_step(fp len2, fp y);
    fp y_sq;
    fp half_term;
    y_sq      = fp_mul(y, y);
    half_term = fp_mul(len2, y_sq) >>> 1;
    return fp_mul(y, fp_sub(FP_THREE_HALVES, half_term));
  endfunction

  // stage 1, squared length and seed
  fp len2_c;
  fp seed_c;

  logic   s1_valid;
  pixel_t s1_pix;
  vec3    s1_vec;
  fp      s1_len2;
  fp      s1_y;

  // stage 2, first refinement
  logic   s2_valid;
  pixel_t s2_pix;
  vec3    s2_vec;
  fp      s2_len2;
  fp      s2_y;

  // stage 3, second refinement
  logic   s3_valid;
  pixel_t s3_pix;
  vec3    s3_vec;
  fp      s3_y;

  // stage 4 unit vector before the flip
  vec3 unit_c;

  assign len2_c = vec3_dot(dir_raw, dir_raw);
  assign seed_c = fp_inv_sqrt_seed(len2_c);
  assign unit_c = vec3_scaled(s3_vec, s3_y);

  // valid chain
  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      s3_valid  <= 1'b0;
      ray_valid <= 1'b0;
    end else begin
      s1_valid  <= valid_in;
      s2_valid  <= s1_valid;
      s3_valid  <= s2_valid;
      ray_valid <= s3_valid;
    end
  end

  // data path
  always_ff @(posedge clk_in) begin
    s1_pix  <= pix;
    s1_vec  <= dir_raw;
    s1_len2 <= len2_c;
    s1_y    <= seed_c;

    s2_pix  <= s1_pix;
    s2_vec  <= s1_vec;
    s2_len2 <= s1_len2;
    s2_y    <= newton_step(s1_len2, s1_y);

    // squared length is no longer needed after this step
    s3_pix  <= s2_pix;
    s3_vec  <= s2_vec;
    s3_y    <= newton_step(s2_len2, s2_y);

    ray.pix   <= s3_pix;
    ray.dir.x <= unit_c.x;
    // screen rows grow downward, so y is flipped
    ray.dir.y <= fp_neg(unit_c.y);
    ray.dir.z <= unit_c.z;
  end

endmodule

//--- ray_generator.sv
`timescale 1ns/1ps

module ray_generator
  import ray_pkg::*;
(
  input  logic   clk_in,
  input  logic   rst_n,
  input  logic   valid_in,
  input  pixel_t pix,
  input  vec3    cam_forward,
  output logic   valid_out,
  output pixel_t pix_out,
  output vec3    dir_raw
);

  // camera basis from world up, not renormalized
  vec3 right_c;
  vec3 up_c;

  // doubled pixel coordinates in fixed point
  fp h2_fp;
  fp v2_fp;

  // screen plane coordinates, y spans about -1 to 1
  fp px_c;
  fp py_c;

  // stage 1 registers
  vec3 right_q;
  vec3 up_q;
  vec3 fwd_q;
  fp   px_q;
  fp   py_q;

  // sideband that rides along with the data
  logic [GEN_LATENCY-1:0] valid_sr;
  pixel_t                 pix_sr [GEN_LATENCY];

  assign right_c = vec3_cross(make_vec3(FP_ZERO, FP_ONE, FP_ZERO), cam_forward);
  assign up_c    = vec3_cross(cam_forward, right_c);

  assign h2_fp = fp'(pix.hcount) <<< (NUM_FRAC_DIGITS + 1);
  assign v2_fp = fp'(pix.vcount) <<< (NUM_FRAC_DIGITS + 1);

  // (2*coord - size) / height, tan(fov/2) taken as one
  assign px_c = fp_mul(fp_sub(h2_fp, FP_DISPLAY_WIDTH), FP_INV_DISPLAY_HEIGHT);
  assign py_c = fp_mul(fp_sub(v2_fp, FP_DISPLAY_HEIGHT), FP_INV_DISPLAY_HEIGHT);

  always_ff @(posedge clk_in) begin
    right_q <= right_c;
    up_q    <= up_c;
    fwd_q   <= cam_forward;
    px_q    <= px_c;
    py_q    <= py_c;
  end

  // stage 2 blends the basis into one direction
  always_ff @(posedge clk_in) begin
    dir_raw <= vec3_add(vec3_add(vec3_scaled(right_q, px_q), vec3_scaled(up_q, py_q)), fwd_q);
  end

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      valid_sr <= '0;
    end else begin
      valid_sr <= {valid_sr[GEN_LATENCY-2:0], valid_in};
    end
  end

  always_ff @(posedge clk_in) begin
    pix_sr[0] <= pix;
    for (int i = 1; i < GEN_LATENCY; i++) begin
      pix_sr[i] <= pix_sr[i-1];
    end
  end

  assign valid_out = valid_sr[GEN_LATENCY-1];
  assign pix_out   = pix_sr[GEN_LATENCY-1];

endmodule

//--- frame_sequencer.sv
`timescale 1ns/1ps

module frame_sequencer
  import ray_pkg::*;
(
  input  logic clk_in,
  input  logic rst_n,
  input  logic start,
  input  vec3  cam_forward,
  input  logic last,
  output logic step,
  output logic clear,
  output logic pix_valid,
  output vec3  cam,
  output logic busy,
  output logic frame_done
);

  // wide enough to count the pipeline drain
  typedef logic [$clog2(PIPE_LATENCY)-1:0] drain_cnt_t;

  seq_state_e state;
  drain_cnt_t drain_cnt;

  // start only counts while idle
  logic accept;

  assign accept = (state == IDLE) && start;

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      state      <= IDLE;
      drain_cnt  <= '0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= 1'b0;
      case (state)
        IDLE: begin
          if (accept) state <= SCAN;
        end
        SCAN: begin
          // final pixel goes out this cycle
          if (last) begin
            state     <= DRAIN;
            drain_cnt <= '0;
          end
        end
        DRAIN: begin
          // wait until the last ray has left the normalizer
          if (drain_cnt == drain_cnt_t'(PIPE_LATENCY - 1)) begin
            state      <= IDLE;
            frame_done <= 1'b1;
          end else begin
            drain_cnt <= drain_cnt + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // camera held for the whole frame
  always_ff @(posedge clk_in) begin
    if (accept) cam <= cam_forward;
  end

  // counter restarts on the accepted start
  assign clear     = accept;
  // one pixel per cycle while scanning
  assign step      = (state == SCAN);
  assign pix_valid = (state == SCAN);
  assign busy      = (state != IDLE);

endmodule

//--- pixel_counter.sv
`timescale 1ns/1ps

module pixel_counter
  import ray_pkg::*;
(
  input  logic   clk_in,
  input  logic   rst_n,
  input  logic   clear,
  input  logic   step,
  output pixel_t pix,
  output logic   last
);

  // true when the current column is the rightmost one
  logic h_wrap;
  // true when the current row is the bottom one
  logic v_wrap;

  assign h_wrap = (pix.hcount == H_BITS'(DISPLAY_WIDTH - 1));
  assign v_wrap = (pix.vcount == V_BITS'(DISPLAY_HEIGHT - 1));

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      pix  <= '0;
      last <= 1'b0;
    end else if (clear) begin
      // restart the raster at the top left
      pix  <= '0;
      last <= 1'b0;
    end else if (step) begin
      if (h_wrap) begin
        pix.hcount <= '0;
        // bottom row wraps back to row zero
        pix.vcount <= v_wrap ? '0 : pix.vcount + 1'b1;
      end else begin
        pix.hcount <= pix.hcount + 1'b1;
      end
      // next pixel is the final one when we sit one left of it
      last <= (pix.hcount == H_BITS'(DISPLAY_WIDTH - 2)) && v_wrap;
    end
  end

endmodule

//--- ray_pkg.sv
package ray_pkg;

  // fixed-point format, signed 16.16
  localparam int NUM_FRAC_DIGITS = 16;

  typedef logic signed [31:0] fp;

  localparam fp FP_ZERO         = 32'sh0000_0000;
  localparam fp FP_ONE          = 32'sh0001_0000;
  localparam fp FP_THREE_HALVES = 32'sh0001_8000;

  // display geometry
  localparam int DISPLAY_WIDTH  = 160;
  localparam int DISPLAY_HEIGHT = 120;
  localparam int H_BITS         = 8;
  localparam int V_BITS         = 7;

  // screen mapping constants, 1/120 rounded to the nearest lsb
  localparam fp FP_DISPLAY_WIDTH      = 32'sh00A0_0000;
  localparam fp FP_DISPLAY_HEIGHT     = 32'sh0078_0000;
  localparam fp FP_INV_DISPLAY_HEIGHT = 32'sh0000_0222;

  // pipeline depths
  localparam int GEN_LATENCY  = 2;
  localparam int NORM_LATENCY = 4;
  localparam int PIPE_LATENCY = GEN_LATENCY + NORM_LATENCY;

  // inverse square root trim factors, indexed by {exponent odd, top mantissa bit}
  // each is the geometric centre of 1/sqrt over its quarter octave pair
  localparam fp INV_SQRT_TRIM_EVEN_LO = 32'sd59218;
  localparam fp INV_SQRT_TRIM_EVEN_HI = 32'sd49797;
  localparam fp INV_SQRT_TRIM_ODD_LO  = 32'sd41873;
  localparam fp INV_SQRT_TRIM_ODD_HI  = 32'sd35212;

  typedef struct packed {
    fp x;
    fp y;
    fp z;
  } vec3;

  typedef struct packed {
    logic [H_BITS-1:0] hcount;
    logic [V_BITS-1:0] vcount;
  } pixel_t;

  typedef struct packed {
    pixel_t pix;
    vec3    dir;
  } ray_t;

  typedef enum logic [1:0] {
    IDLE,
    SCAN,
    DRAIN
  } seq_state_e;

  // full 64 bit product, keep the middle 32 bits
  function automatic fp fp_mul(fp a, fp b);
    logic signed [63:0] prod;
    prod = a * b;
    return prod[NUM_FRAC_DIGITS +: 32];
  endfunction

  function automatic fp fp_add(fp a, fp b);
    return a + b;
  endfunction

  function automatic fp fp_sub(fp a, fp b);
    return a - b;
  endfunction

  function automatic fp fp_neg(fp a);
    return -a;
  endfunction

  function automatic vec3 make_vec3(fp x, fp y, fp z);
    vec3 v;
    v.x = x;
    v.y = y;
    v.z = z;
    return v;
  endfunction

  function automatic vec3 vec3_add(vec3 a, vec3 b);
    return make_vec3(fp_add(a.x, b.x), fp_add(a.y, b.y), fp_add(a.z, b.z));
  endfunction

  function automatic vec3 vec3_scaled(vec3 a, fp s);
    return make_vec3(fp_mul(a.x, s), fp_mul(a.y, s), fp_mul(a.z, s));
  endfunction

  function automatic vec3 vec3_cross(vec3 a, vec3 b);
    return make_vec3(fp_sub(fp_mul(a.y, b.z), fp_mul(a.z, b.y)),
                     fp_sub(fp_mul(a.z, b.x), fp_mul(a.x, b.z)),
                     fp_sub(fp_mul(a.x, b.y), fp_mul(a.y, b.x)));
  endfunction

  function automatic fp vec3_dot(vec3 a, vec3 b);
    return fp_add(fp_add(fp_mul(a.x, b.x), fp_mul(a.y, b.y)), fp_mul(a.z, b.z));
  endfunction

  // first estimate of 1/sqrt(a) for a positive a
  // power of two from the leading one, trimmed by the next mantissa bit
  function automatic fp fp_inv_sqrt_seed(fp a);
    int   pos;
    int   k;
    logic mant;
    fp    trim;
    pos = 0;
    for (int i = 0; i < 31; i++) begin
      if (a[i]) pos = i;
    end
    mant = (pos > 0) ? a[pos-1] : 1'b0;
    // a is about 2^(2k-16) scaled by 1..4, so 1/sqrt(a) is about 2^(8-k)
    k = pos >> 1;
    case ({pos[0], mant})
      2'b00:   trim = INV_SQRT_TRIM_EVEN_LO;
      2'b01:   trim = INV_SQRT_TRIM_EVEN_HI;
      2'b10:   trim = INV_SQRT_TRIM_ODD_LO;
      default: trim = INV_SQRT_TRIM_ODD_HI;
    endcase
    if (k <= 8) return trim << (8 - k);
    return trim >>> (k - 8);
  endfunction

endpackage
